/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_dma_rd_top
FILELIST  := dma_rd_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dma_buf_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_buf_mem (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [`DMA_ADDR_W-1:0] addr,
    input  dma_rd_pkg::dma_word_t  wdata,
    output dma_rd_pkg::dma_word_t  rdata
);

    dma_rd_pkg::dma_word_t mem_q [`DMA_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem_q[addr] <= wdata;
            else
                rdata <= mem_q[addr]; // rdata holds until the next read
        end
    end

endmodule

`default_nettype wire

/* dma_line_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_line_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  dma_rd_pkg::dma_line_t push_line,
    input  logic                  pop,
    output dma_rd_pkg::dma_line_t head_line,
    output logic                  empty,
    output logic                  full
);

    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dma_rd_pkg::dma_line_t buf_q [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign head_line = buf_q[rd_ptr]; // head is visible before the pop

    always_ff @(posedge clk) begin
        if (do_push)
            buf_q[wr_ptr] <= push_line;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the source watches src_full, the sequencer only pops after it saw a line
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
        else $error("line pushed while the FIFO is full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
        else $error("line popped while the FIFO is empty");

endmodule

`default_nettype wire

/* dma_line_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_line_unpack (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  dma_rd_pkg::dma_line_t line_in,
    input  logic                  shift,
    output dma_rd_pkg::dma_word_t word
);

    dma_rd_pkg::dma_line_t line_q;

    // the word written to memory in a shift cycle is the one shown before the shift
    assign word = line_q[`DMA_WORD_W-1:0];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            line_q <= '0;
        end else if (load) begin
            line_q <= line_in;
        end else if (shift) begin
            line_q <= line_q >> `DMA_WORD_W; // next word moves into the low bits
        end
    end

endmodule

`default_nettype wire

/* dma_rd_cfg.svh */
`ifndef DMA_RD_CFG_SVH
`define DMA_RD_CFG_SVH

// one memory word and the number of them in a source line
`define DMA_WORD_W 32
`define DMA_WORDS 4
`define DMA_LINE_W (`DMA_WORD_W * `DMA_WORDS)

`define DMA_FIFO_DEPTH 4

`define DMA_MEM_DEPTH 64
`define DMA_ADDR_W 6
`define DMA_STATUS_ADDR (`DMA_MEM_DEPTH - 1) // status word lives in the last memory word

`endif

/* dma_rd_chan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_chan (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dma_start,
    output logic                  dma_go,
    output logic                  dma_end,
    input  logic                  src_push,
    input  dma_rd_pkg::dma_line_t src_line,
    output logic                  src_full,
    input  logic                  src_done,
    output dma_rd_pkg::mem_wr_t   dma_wr
);

    dma_rd_pkg::dma_line_t    head_line;
    dma_rd_pkg::dma_word_t    unpack_word;
    dma_rd_pkg::dma_word_t    word_count;
    dma_rd_pkg::mem_wr_kind_e wr_kind;
    logic [`DMA_ADDR_W-1:0]   wr_addr;
    logic                     fifo_empty;
    logic                     fifo_pop;
    logic                     line_load;
    logic                     line_shift;
    logic                     done_clr;
    logic                     done_q;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            done_q <= 1'b0;
        else if (done_clr)
            done_q <= 1'b0;
        else if (src_done)
            done_q <= 1'b1;
    end

    // both restart on go, the address may wrap but the count keeps going
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_addr    <= '0;
            word_count <= '0;
        end else if (dma_go) begin
            wr_addr    <= '0;
            word_count <= '0;
        end else if (wr_kind == dma_rd_pkg::MEM_WR_DATA) begin
            wr_addr    <= wr_addr + 1'b1;
            word_count <= word_count + 1'b1;
        end
    end

    always_comb begin
        dma_wr.en = (wr_kind != dma_rd_pkg::MEM_WR_NONE);
        if (wr_kind == dma_rd_pkg::MEM_WR_STATUS) begin
            dma_wr.addr = `DMA_ADDR_W'(`DMA_STATUS_ADDR);
            dma_wr.data = word_count;
        end else begin
            dma_wr.addr = wr_addr;
            dma_wr.data = unpack_word;
        end
    end

    dma_line_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (src_push),
        .push_line (src_line),
        .pop       (fifo_pop),
        .head_line (head_line),
        .empty     (fifo_empty),
        .full      (src_full)
    );

    dma_line_unpack u_unpack (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (line_load),
        .line_in (head_line),
        .shift   (line_shift),
        .word    (unpack_word)
    );

    dma_rd_seq #(
        .WORDS (`DMA_WORDS)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_start   (dma_start),
        .rd_done    (done_q),
        .fifo_empty (fifo_empty),
        .rd_end     (dma_end),
        .rd_go      (dma_go),
        .fifo_pop   (fifo_pop),
        .line_load  (line_load),
        .line_shift (line_shift),
        .done_clr   (done_clr),
        .wr_kind    (wr_kind)
    );

endmodule

`default_nettype wire

/* dma_rd_pkg.sv */
`default_nettype none

`include "dma_rd_cfg.svh"

package dma_rd_pkg;

    // word 0 of a line sits in the low bits
    typedef logic [`DMA_LINE_W-1:0] dma_line_t;

    typedef logic [`DMA_WORD_W-1:0] dma_word_t;

    typedef enum logic [1:0] {
        MEM_WR_NONE   = 2'b00,
        MEM_WR_DATA   = 2'b01,
        MEM_WR_STATUS = 2'b10
    } mem_wr_kind_e;

    typedef struct packed {
        logic                   en;
        logic [`DMA_ADDR_W-1:0] addr;
        dma_word_t              data;
    } mem_wr_t;

    typedef struct packed {
        logic                   req;  // held as a level until host_rd_valid
        logic [`DMA_ADDR_W-1:0] addr;
    } host_rd_req_t;

endpackage

`default_nettype wire

/* dma_rd_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_seq #(
    parameter int WORDS = `DMA_WORDS
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_start,
    input  logic                     rd_done,
    input  logic                     fifo_empty,
    output logic                     rd_end,
    output logic                     rd_go,
    output logic                     fifo_pop,
    output logic                     line_load,
    output logic                     line_shift,
    output logic                     done_clr,
    output dma_rd_pkg::mem_wr_kind_e wr_kind
);

    localparam int CNT_W = $clog2(WORDS + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GO,
        ST_WAIT,
        ST_HOLD,
        ST_LOAD
    } seq_state_e;

    seq_state_e       state;
    seq_state_e       nxt_state;
    logic [CNT_W-1:0] word_cnt;
    logic             cnt_clr;
    logic             cnt_inc;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            word_cnt <= '0;
        else if (cnt_clr)
            word_cnt <= '0;
        else if (cnt_inc)
            word_cnt <= word_cnt + 1'b1;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state  = ST_IDLE;
        rd_end     = 1'b0;
        rd_go      = 1'b0;
        fifo_pop   = 1'b0;
        line_load  = 1'b0;
        line_shift = 1'b0;
        done_clr   = 1'b0;
        cnt_clr    = 1'b0;
        cnt_inc    = 1'b0;
        wr_kind    = dma_rd_pkg::MEM_WR_NONE;

        case (state)
            ST_IDLE: begin
                if (rd_start)
                    nxt_state = ST_GO;
            end
            ST_GO: begin
                nxt_state = ST_WAIT;
                rd_go     = 1'b1;
            end
            ST_WAIT: begin
                // done wins over a waiting line and ends the transfer
                if (rd_done) begin
                    rd_end   = 1'b1;
                    done_clr = 1'b1;
                    wr_kind  = dma_rd_pkg::MEM_WR_STATUS;
                end else if (!fifo_empty) begin
                    nxt_state = ST_HOLD;
                    line_load = 1'b1;
                end else begin
                    nxt_state = ST_WAIT;
                end
            end
            ST_HOLD: begin
                nxt_state  = ST_LOAD;
                fifo_pop   = 1'b1; // line already sits in the unpacker
                line_shift = 1'b1;
                cnt_inc    = 1'b1;
                wr_kind    = dma_rd_pkg::MEM_WR_DATA;
            end
            default: begin
                if (word_cnt == CNT_W'(WORDS)) begin
                    nxt_state = ST_WAIT; // idle decision cycle
                    cnt_clr   = 1'b1;
                end else begin
                    nxt_state  = ST_LOAD;
                    line_shift = 1'b1;
                    cnt_inc    = 1'b1;
                    wr_kind    = dma_rd_pkg::MEM_WR_DATA;
                end
            end
        endcase
    end

    a_no_shift_on_status: assert property (@(posedge clk) disable iff (!rst_n)
        line_shift |-> wr_kind != dma_rd_pkg::MEM_WR_STATUS)
        else $error("unpacker shifted during a status write");

endmodule

`default_nettype wire

/* dma_rd_top.f */
+incdir+.
dma_rd_pkg.sv
dma_line_fifo.sv
dma_line_unpack.sv
dma_rd_seq.sv
dma_rd_chan.sv
mem_port_arb.sv
dma_buf_mem.sv
dma_rd_top.sv
tb_dma_rd_top.sv

/* dma_rd_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dma_start,
    output logic                     dma_go,
    output logic                     dma_end,
    input  logic                     src_push,
    input  dma_rd_pkg::dma_line_t    src_line,
    output logic                     src_full,
    input  logic                     src_done,
    input  dma_rd_pkg::host_rd_req_t host_req,
    output logic                     host_rd_valid,
    output dma_rd_pkg::dma_word_t    host_rd_data
);

    dma_rd_pkg::mem_wr_t    dma_wr;
    dma_rd_pkg::dma_word_t  mem_wdata;
    logic [`DMA_ADDR_W-1:0] mem_addr;
    logic                   mem_en;
    logic                   mem_we;

    dma_rd_chan u_chan (
        .clk       (clk),
        .rst_n     (rst_n),
        .dma_start (dma_start),
        .dma_go    (dma_go),
        .dma_end   (dma_end),
        .src_push  (src_push),
        .src_line  (src_line),
        .src_full  (src_full),
        .src_done  (src_done),
        .dma_wr    (dma_wr)
    );

    mem_port_arb u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .dma_wr        (dma_wr),
        .host_req      (host_req),
        .host_rd_valid (host_rd_valid),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    dma_buf_mem u_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (host_rd_data)
    );

endmodule

`default_nettype wire

/* mem_port_arb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module mem_port_arb (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dma_rd_pkg::mem_wr_t      dma_wr,
    input  dma_rd_pkg::host_rd_req_t host_req,
    output logic                     host_rd_valid,
    output logic                     mem_en,
    output logic                     mem_we,
    output logic [`DMA_ADDR_W-1:0]   mem_addr,
    output dma_rd_pkg::dma_word_t    mem_wdata
);

    logic host_grant;
    logic host_busy;

    // a DMA write is never stalled, the host only gets free cycles
    assign host_grant = host_req.req && !host_busy && !dma_wr.en;
    assign mem_en     = dma_wr.en || host_grant;
    assign mem_we     = dma_wr.en;
    assign mem_addr   = dma_wr.en ? dma_wr.addr : host_req.addr;
    assign mem_wdata  = dma_wr.data;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            host_rd_valid <= 1'b0;
            host_busy     <= 1'b0;
        end else begin
            host_rd_valid <= host_grant; // memory data lands one cycle later
            if (host_grant)
                host_busy <= 1'b1;
            else if (!host_req.req)
                host_busy <= 1'b0; // the host has dropped the served request
        end
    end

    a_host_after_free_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid |-> $past(host_req.req && !dma_wr.en))
        else $error("host read issued in a cycle with a DMA write");

endmodule

`default_nettype wire

/* tb_dma_rd_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module tb_dma_rd_top;

    localparam int TIMEOUT = 200;
    localparam int LINE_CYCLES = `DMA_WORDS + 2; // load, one write per word, decision cycle
    localparam int W_GO = 0;
    localparam int W_END = 1;
    localparam int W_FULL = 2;
    localparam int W_VALID = 3;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     dma_start;
    logic                     dma_go;
    logic                     dma_end;
    logic                     src_push;
    dma_rd_pkg::dma_line_t    src_line;
    logic                     src_full;
    logic                     src_done;
    dma_rd_pkg::host_rd_req_t host_req;
    logic                     host_rd_valid;
    dma_rd_pkg::dma_word_t    host_rd_data;

    dma_rd_pkg::dma_line_t lines_q[$]; // lines pushed in the current transfer
    int          status_cnt = 0;       // word count of the last finished transfer
    logic [15:0] lfsr_state = 16'd46355;
    int          go_cnt = 0;
    int          end_cnt = 0;
    int          rd_checks = 0;
    int          rd_errs = 0;
    int          main_checks = 0;
    int          main_errs = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    always #20 clk = ~clk;

    dma_rd_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .dma_start     (dma_start),
        .dma_go        (dma_go),
        .dma_end       (dma_end),
        .src_push      (src_push),
        .src_line      (src_line),
        .src_full      (src_full),
        .src_done      (src_done),
        .host_req      (host_req),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // data words follow line order with word 0 first, the status word holds the count
    function automatic dma_rd_pkg::dma_word_t ref_word(input int addr);
        dma_rd_pkg::dma_line_t line;
        int li;
        int wi;
        li = addr / `DMA_WORDS;
        wi = addr % `DMA_WORDS;
        if (addr == `DMA_STATUS_ADDR)
            return dma_rd_pkg::dma_word_t'(status_cnt);
        if (li >= lines_q.size())
            return '0;
        line = lines_q[li];
        return line[wi*`DMA_WORD_W +: `DMA_WORD_W];
    endfunction

    function automatic bit level_of(input int sel);
        case (sel)
            W_GO:    return dma_go;
            W_END:   return dma_end;
            W_FULL:  return src_full;
            default: return host_rd_valid;
        endcase
    endfunction

    function automatic int total_errors();
        return main_errs + rd_errs;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
                         output bit ok);
        ok = (got === exp);
        if (!ok)
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic verify(input string name, input logic [31:0] got, input logic [31:0] exp);
        bit ok;
        check(name, got, exp, ok);
        main_checks++;
        if (!ok)
            main_errs++;
    endtask

    task automatic fail(input string msg);
        $display("%s", msg);
        main_errs++;
    endtask

    // outputs are sampled at falling edges, away from the rising edge that moves them
    task automatic wait_high(input int sel, input string what);
        int i;
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (level_of(sel))
                break;
        end
        if (i == TIMEOUT)
            fail($sformatf("timed out at %0t ns waiting for %s", $time, what));
    endtask

    task automatic make_line(output dma_rd_pkg::dma_line_t line);
        for (int i = 0; i < `DMA_LINE_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            line[i] = lfsr_state[0];
        end
    endtask

    task automatic push_lines(input int n);
        dma_rd_pkg::dma_line_t line;
        for (int i = 0; i < n; i++) begin
            make_line(line);
            @(negedge clk);
            if (src_full)
                fail("the FIFO was full before a line could be pushed");
            @(posedge clk);
            src_push <= 1'b1;
            src_line <= line;
            lines_q.push_back(line);
        end
        @(posedge clk);
        src_push <= 1'b0;
    endtask

    task automatic start_transfer();
        @(posedge clk);
        dma_start <= 1'b1;
        @(posedge clk);
        dma_start <= 1'b0;
        wait_high(W_GO, "dma_go after the start strobe");
    endtask

    task automatic finish_transfer();
        repeat (lines_q.size() * LINE_CYCLES + 4) @(posedge clk); // let every line drain first
        src_done <= 1'b1;
        @(posedge clk);
        src_done <= 1'b0;
        wait_high(W_END, "dma_end after src_done");
        status_cnt = lines_q.size() * `DMA_WORDS;
    endtask

    task automatic host_read(input int addr);
        @(posedge clk);
        host_req.req  <= 1'b1;
        host_req.addr <= `DMA_ADDR_W'(addr);
        wait_high(W_VALID, $sformatf("host_rd_valid for address %0d", addr));
        @(posedge clk);
        host_req <= '0;
    endtask

    task automatic read_range(input int first, input int n);
        for (int i = 0; i < n; i++)
            host_read(first + i);
    endtask

    task automatic end_test(input string name, input int base);
        if (total_errors() == base) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    always @(negedge clk) begin
        if (dma_go)
            go_cnt++;
        if (dma_end)
            end_cnt++;
    end

    // every host read is compared with the reference model as its data returns
    always @(negedge clk) begin
        bit ok;
        if (host_rd_valid) begin
            check($sformatf("host_rd_data[%0d]", host_req.addr), host_rd_data,
                  ref_word(int'(host_req.addr)), ok);
            rd_checks++;
            if (!ok)
                rd_errs++;
        end
    end

    initial begin
        int base;
        int go_base;
        int end_base;
        rst_n     = 1'b0;
        dma_start = 1'b0;
        src_push  = 1'b0;
        src_line  = '0;
        src_done  = 1'b0;
        host_req  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        base = total_errors();
        @(negedge clk);
        verify("dma_go", 32'(dma_go), 32'd0);
        verify("dma_end", 32'(dma_end), 32'd0);
        verify("host_rd_valid", 32'(host_rd_valid), 32'd0);
        go_base = go_cnt;
        start_transfer();
        repeat (4) @(negedge clk);
        verify("dma_go pulse count", go_cnt - go_base, 1);
        end_test("reset and go", base);

        base = total_errors();
        lines_q.delete();
        push_lines(3);
        end_base = end_cnt;
        finish_transfer();
        repeat (4) @(negedge clk);
        verify("dma_end pulse count", end_cnt - end_base, 1);
        read_range(0, 3 * `DMA_WORDS);
        end_test("single transfer", base);

        base = total_errors();
        host_read(`DMA_STATUS_ADDR);
        end_test("status word", base);

        base = total_errors();
        lines_q.delete();
        start_transfer();
        push_lines(2);
        finish_transfer();
        read_range(0, 2 * `DMA_WORDS);
        host_read(`DMA_STATUS_ADDR);
        end_test("word order and restart", base);

        // the read of the last word waits out the unpacking of the new line and sees its data
        base = total_errors();
        lines_q.delete();
        start_transfer();
        push_lines(1);
        host_read(`DMA_WORDS - 1);
        finish_transfer();
        read_range(0, `DMA_WORDS);
        host_read(`DMA_STATUS_ADDR);
        end_test("host read during DMA", base);

        base = total_errors();
        lines_q.delete();
        push_lines(`DMA_FIFO_DEPTH);
        wait_high(W_FULL, "src_full after filling the FIFO");
        start_transfer();
        finish_transfer();
        read_range(0, `DMA_FIFO_DEPTH * `DMA_WORDS);
        host_read(`DMA_STATUS_ADDR);
        end_test("FIFO full", base);

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_passed, tests_failed, main_checks + rd_checks, total_errors());
        if (total_errors() == 0 && tests_failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
